/* hw/aes_ctrl_regs.sv */
// Host register file holding the job description and key, decoding COMMAND into start and clear pulses
`default_nettype none

module aes_ctrl_regs (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        cfg_we_i,
  input  aes_hwpe_pkg::reg_idx_t      cfg_idx_i,
  input  aes_hwpe_pkg::word_t         cfg_wdata_i,
  input  logic                        busy_i,
  output aes_hwpe_pkg::ctrl_regfile_t regs_o,
  output logic                        start_o,
  output logic                        clear_o
);

  aes_hwpe_pkg::ctrl_regfile_t regs_q;
  logic                        cmd_write;
  logic                        param_lock;

  assign cmd_write  = cfg_we_i && (cfg_idx_i == aes_hwpe_pkg::REG_COMMAND);
  // Also lock in the start cycle, before busy rises
  assign param_lock = busy_i || start_o;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      regs_q <= '0;
    end else if (cfg_we_i && !param_lock) begin
      case (cfg_idx_i)
        aes_hwpe_pkg::REG_INPUT_ADDR:  regs_q.input_addr  <= cfg_wdata_i;
        aes_hwpe_pkg::REG_OUTPUT_ADDR: regs_q.output_addr <= cfg_wdata_i;
        aes_hwpe_pkg::REG_BYTE_LENGTH: regs_q.byte_length <= cfg_wdata_i;
        // KEY0 is the least significant key word
        aes_hwpe_pkg::REG_KEY0:        regs_q.key[31:0]   <= cfg_wdata_i;
        aes_hwpe_pkg::REG_KEY1:        regs_q.key[63:32]  <= cfg_wdata_i;
        aes_hwpe_pkg::REG_KEY2:        regs_q.key[95:64]  <= cfg_wdata_i;
        aes_hwpe_pkg::REG_KEY3:        regs_q.key[127:96] <= cfg_wdata_i;
        default: begin
          regs_q <= regs_q;
        end
      endcase
    end
  end

  // Command pulses, clear takes priority over start
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      start_o <= 1'b0;
      clear_o <= 1'b0;
    end else begin
      start_o <= cmd_write && cfg_wdata_i[aes_hwpe_pkg::CMD_START_BIT]
                 && !cfg_wdata_i[aes_hwpe_pkg::CMD_CLEAR_BIT] && !param_lock;
      clear_o <= cmd_write && cfg_wdata_i[aes_hwpe_pkg::CMD_CLEAR_BIT];
    end
  end

  assign regs_o = regs_q;

endmodule

`default_nettype wire

/* hw/aes_fsm.sv */
// Block sequencer that fetches, whitens and writes back each block, raising done at the end of a job
`default_nettype none

module aes_fsm #(
  parameter int unsigned BLOCK_WORDS = 4
) (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          clear_i,
  input  logic                          start_i,
  input  aes_hwpe_pkg::ctrl_regfile_t   regs_i,
  output aes_hwpe_pkg::ctrl_streamer_t  streamer_ctrl_o,
  input  aes_hwpe_pkg::flags_streamer_t streamer_flags_i,
  output aes_hwpe_pkg::ctrl_engine_t    ctrl_engine_o,
  output logic                          busy_o,
  output logic                          done_o
);

  localparam int unsigned      CNT_W     = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(BLOCK_WORDS - 1);

  aes_hwpe_pkg::aes_state_t state_q;
  aes_hwpe_pkg::aes_state_t state_d;
  logic [CNT_W-1:0]         word_cnt_q;
  logic                     word_cnt_en;
  aes_hwpe_pkg::word_t      blocks_left_q;
  aes_hwpe_pkg::addr_t      block_off_q;
  aes_hwpe_pkg::addr_t      word_off;
  logic                     last_block;
  logic                     zero_len;

  // Only whole 16-byte blocks count
  assign zero_len   = (regs_i.byte_length[31:4] == '0);
  assign last_block = (blocks_left_q <= aes_hwpe_pkg::word_t'(1));
  assign word_off   = aes_hwpe_pkg::addr_t'(block_off_q * BLOCK_WORDS)
                      + aes_hwpe_pkg::addr_t'(word_cnt_q);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= aes_hwpe_pkg::AES_IDLE;
    end else if (clear_i) begin
      state_q <= aes_hwpe_pkg::AES_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word counter, restarted at every block phase boundary
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      word_cnt_q <= '0;
    end else if (clear_i || state_q == aes_hwpe_pkg::AES_STARTING ||
                 state_q == aes_hwpe_pkg::AES_WORKING ||
                 state_q == aes_hwpe_pkg::AES_FINISHED) begin
      word_cnt_q <= '0;
    end else if (word_cnt_en) begin
      word_cnt_q <= word_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      blocks_left_q <= '0;
      block_off_q   <= '0;
    end else if (state_q == aes_hwpe_pkg::AES_STARTING) begin
      blocks_left_q <= {4'b0000, regs_i.byte_length[31:4]};
      block_off_q   <= '0;
    end else if (state_q == aes_hwpe_pkg::AES_FINISHED && !last_block) begin
      blocks_left_q <= blocks_left_q - 1'b1;
      block_off_q   <= block_off_q + 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      aes_hwpe_pkg::AES_IDLE: begin
        if (start_i) begin
          state_d = aes_hwpe_pkg::AES_STARTING;
        end
      end
      aes_hwpe_pkg::AES_STARTING: begin
        state_d = zero_len ? aes_hwpe_pkg::AES_FINISHED : aes_hwpe_pkg::AES_REQUEST_DATA;
      end
      aes_hwpe_pkg::AES_REQUEST_DATA: begin
        state_d = aes_hwpe_pkg::AES_REQUEST_DATA_WAIT;
      end
      aes_hwpe_pkg::AES_REQUEST_DATA_WAIT: begin
        if (streamer_flags_i.src_done) begin
          state_d = (word_cnt_q == LAST_WORD) ? aes_hwpe_pkg::AES_WORKING
                                              : aes_hwpe_pkg::AES_REQUEST_DATA;
        end
      end
      aes_hwpe_pkg::AES_WORKING: begin
        state_d = aes_hwpe_pkg::AES_SEND_DATA;
      end
      aes_hwpe_pkg::AES_SEND_DATA: begin
        state_d = aes_hwpe_pkg::AES_SEND_DATA_WAIT;
      end
      aes_hwpe_pkg::AES_SEND_DATA_WAIT: begin
        if (streamer_flags_i.snk_done) begin
          state_d = aes_hwpe_pkg::AES_MEMORY_WRITE_WAIT;
        end
      end
      aes_hwpe_pkg::AES_MEMORY_WRITE_WAIT: begin
        state_d = (word_cnt_q == LAST_WORD) ? aes_hwpe_pkg::AES_FINISHED
                                            : aes_hwpe_pkg::AES_SEND_DATA;
      end
      aes_hwpe_pkg::AES_FINISHED: begin
        state_d = last_block ? aes_hwpe_pkg::AES_IDLE : aes_hwpe_pkg::AES_REQUEST_DATA;
      end
      default: begin
        state_d = aes_hwpe_pkg::AES_IDLE;
      end
    endcase
  end

  always_comb begin
    word_cnt_en = 1'b0;
    done_o      = 1'b0;

    streamer_ctrl_o.src_req_start = 1'b0;
    streamer_ctrl_o.src_addr      = regs_i.input_addr + (word_off << 2);
    streamer_ctrl_o.snk_req_start = 1'b0;
    streamer_ctrl_o.snk_addr      = regs_i.output_addr + (word_off << 2);

    ctrl_engine_o.clear          = (state_q == aes_hwpe_pkg::AES_IDLE);
    ctrl_engine_o.load           = 1'b0;
    ctrl_engine_o.word_idx       = aes_hwpe_pkg::word_idx_t'(word_cnt_q);
    ctrl_engine_o.load_word      = streamer_flags_i.src_word;
    ctrl_engine_o.enable         = 1'b0;
    ctrl_engine_o.data_out_valid = 1'b0;

    case (state_q)
      aes_hwpe_pkg::AES_REQUEST_DATA: begin
        streamer_ctrl_o.src_req_start = 1'b1;
      end
      aes_hwpe_pkg::AES_REQUEST_DATA_WAIT: begin
        if (streamer_flags_i.src_done) begin
          ctrl_engine_o.load = 1'b1;
          word_cnt_en        = 1'b1;
        end
      end
      aes_hwpe_pkg::AES_WORKING: begin
        ctrl_engine_o.enable = 1'b1;
      end
      aes_hwpe_pkg::AES_SEND_DATA: begin
        // Sink samples the engine word together with the request
        streamer_ctrl_o.snk_req_start = 1'b1;
        ctrl_engine_o.data_out_valid  = 1'b1;
      end
      aes_hwpe_pkg::AES_MEMORY_WRITE_WAIT: begin
        word_cnt_en = 1'b1;
      end
      aes_hwpe_pkg::AES_FINISHED: begin
        done_o = last_block && !clear_i;
      end
      default: begin
        word_cnt_en = 1'b0;
      end
    endcase
  end

  assign busy_o = (state_q != aes_hwpe_pkg::AES_IDLE);

endmodule

`default_nettype wire

/* hw/aes_hwpe_pkg.sv */
// Shared widths, register map, control and flag bundles, and FSM states for the whitening engine
`default_nettype none

package aes_hwpe_pkg;

  localparam int unsigned WORD_WIDTH          = 32;
  // Key width and default block size
  localparam int unsigned BLOCK_WORDS_DEFAULT = 4;

  typedef logic [WORD_WIDTH-1:0]                     word_t;
  typedef logic [WORD_WIDTH-1:0]                     addr_t;
  typedef logic [BLOCK_WORDS_DEFAULT*WORD_WIDTH-1:0] block_t;
  typedef logic [1:0]                                word_idx_t;
  typedef logic [2:0]                                reg_idx_t;

  // Host register map
  localparam reg_idx_t REG_INPUT_ADDR  = 3'd0;
  localparam reg_idx_t REG_OUTPUT_ADDR = 3'd1;
  localparam reg_idx_t REG_BYTE_LENGTH = 3'd2;
  localparam reg_idx_t REG_KEY0        = 3'd3;
  localparam reg_idx_t REG_KEY1        = 3'd4;
  localparam reg_idx_t REG_KEY2        = 3'd5;
  localparam reg_idx_t REG_KEY3        = 3'd6;
  localparam reg_idx_t REG_COMMAND     = 3'd7;

  // COMMAND register bits
  localparam int unsigned CMD_START_BIT = 0;
  localparam int unsigned CMD_CLEAR_BIT = 1;

  typedef enum logic [3:0] {
    AES_IDLE,
    AES_STARTING,
    AES_REQUEST_DATA,
    AES_REQUEST_DATA_WAIT,
    AES_WORKING,
    AES_SEND_DATA,
    AES_SEND_DATA_WAIT,
    AES_MEMORY_WRITE_WAIT,
    AES_FINISHED
  } aes_state_t;

  typedef struct packed {
    addr_t  input_addr;
    addr_t  output_addr;
    word_t  byte_length;
    block_t key;
  } ctrl_regfile_t;

  typedef struct packed {
    logic  src_req_start;
    addr_t src_addr;
    logic  snk_req_start;
    addr_t snk_addr;
  } ctrl_streamer_t;

  typedef struct packed {
    logic  src_done;
    word_t src_word;
    logic  snk_done;
  } flags_streamer_t;

  typedef struct packed {
    logic      clear;
    logic      load;
    word_idx_t word_idx;
    word_t     load_word;
    logic      enable;
    logic      data_out_valid;
  } ctrl_engine_t;

  typedef struct packed {
    word_t out_word;
  } flags_engine_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_port_t;

endpackage

`default_nettype wire

/* hw/aes_hwpe_top.sv */
// Top level of the whitening accelerator with a host write port and a single-word memory port
`default_nettype none

module aes_hwpe_top #(
  parameter int unsigned BLOCK_WORDS = 4
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    cfg_we_i,
  input  aes_hwpe_pkg::reg_idx_t  cfg_idx_i,
  input  aes_hwpe_pkg::word_t     cfg_wdata_i,
  output aes_hwpe_pkg::mem_port_t mem_o,
  input  aes_hwpe_pkg::word_t     mem_rdata_i,
  output logic                    busy_o,
  output logic                    done_o
);

  aes_hwpe_pkg::ctrl_regfile_t   regs;
  logic                          start;
  logic                          clear;
  aes_hwpe_pkg::ctrl_streamer_t  streamer_ctrl;
  aes_hwpe_pkg::flags_streamer_t streamer_flags;
  aes_hwpe_pkg::ctrl_engine_t    engine_ctrl;
  aes_hwpe_pkg::flags_engine_t   engine_flags;

  aes_ctrl_regs aes_ctrl_regs_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_idx_i   (cfg_idx_i),
    .cfg_wdata_i (cfg_wdata_i),
    .busy_i      (busy_o),
    .regs_o      (regs),
    .start_o     (start),
    .clear_o     (clear)
  );

  aes_fsm #(
    .BLOCK_WORDS (BLOCK_WORDS)
  ) aes_fsm_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .clear_i          (clear),
    .start_i          (start),
    .regs_i           (regs),
    .streamer_ctrl_o  (streamer_ctrl),
    .streamer_flags_i (streamer_flags),
    .ctrl_engine_o    (engine_ctrl),
    .busy_o           (busy_o),
    .done_o           (done_o)
  );

  // Sink write data comes straight from the engine result word
  aes_streamer aes_streamer_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .clear_i     (clear),
    .ctrl_i      (streamer_ctrl),
    .wdata_i     (engine_flags.out_word),
    .flags_o     (streamer_flags),
    .mem_o       (mem_o),
    .mem_rdata_i (mem_rdata_i)
  );

  aes_whitening_engine #(
    .BLOCK_WORDS (BLOCK_WORDS)
  ) aes_whitening_engine_i (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl_i  (engine_ctrl),
    .key_i   (regs.key),
    .flags_o (engine_flags)
  );

endmodule

`default_nettype wire

/* hw/aes_streamer.sv */
// Input source and output sink turning FSM request pulses into single-word memory reads and writes
`default_nettype none

module aes_streamer (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          clear_i,
  input  aes_hwpe_pkg::ctrl_streamer_t  ctrl_i,
  input  aes_hwpe_pkg::word_t           wdata_i,
  output aes_hwpe_pkg::flags_streamer_t flags_o,
  output aes_hwpe_pkg::mem_port_t       mem_o,
  input  aes_hwpe_pkg::word_t           mem_rdata_i
);

  aes_hwpe_pkg::mem_port_t mem_q;
  logic                    rd_pending_q;

  // Registered memory strobe, one word per request
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mem_q <= '0;
    end else if (clear_i) begin
      mem_q.req <= 1'b0;
      mem_q.we  <= 1'b0;
    end else if (ctrl_i.src_req_start) begin
      mem_q.req  <= 1'b1;
      mem_q.we   <= 1'b0;
      mem_q.addr <= ctrl_i.src_addr;
    end else if (ctrl_i.snk_req_start) begin
      mem_q.req   <= 1'b1;
      mem_q.we    <= 1'b1;
      mem_q.addr  <= ctrl_i.snk_addr;
      mem_q.wdata <= wdata_i;
    end else begin
      mem_q.req <= 1'b0;
      mem_q.we  <= 1'b0;
    end
  end

  // Read data returns one cycle after the strobe
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_pending_q <= 1'b0;
    end else if (clear_i) begin
      rd_pending_q <= 1'b0;
    end else begin
      rd_pending_q <= mem_q.req && !mem_q.we;
    end
  end

  assign mem_o = mem_q;

  assign flags_o.src_done = rd_pending_q;
  assign flags_o.src_word = mem_rdata_i;
  // Writes complete in the strobe cycle
  assign flags_o.snk_done = mem_q.req && mem_q.we;

endmodule

`default_nettype wire

/* hw/aes_whitening_engine.sv */
// Block buffer that gathers words, XORs the block with the key and returns result words by index
`default_nettype none

module aes_whitening_engine #(
  parameter int unsigned BLOCK_WORDS = 4
) (
  input  logic                        clk,
  input  logic                        reset_n,
  input  aes_hwpe_pkg::ctrl_engine_t  ctrl_i,
  input  aes_hwpe_pkg::block_t        key_i,
  output aes_hwpe_pkg::flags_engine_t flags_o
);

  localparam int unsigned KEY_WORDS = aes_hwpe_pkg::BLOCK_WORDS_DEFAULT;

  aes_hwpe_pkg::word_t [BLOCK_WORDS-1:0] block_q;
  aes_hwpe_pkg::word_t [KEY_WORDS-1:0]   key_words;

  // Word 0 of the key is its least significant word
  assign key_words = key_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      block_q <= '0;
    end else if (ctrl_i.clear) begin
      block_q <= '0;
    end else if (ctrl_i.enable) begin
      // AddRoundKey only, longer blocks reuse the key cyclically
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        block_q[i] <= block_q[i] ^ key_words[i % KEY_WORDS];
      end
    end else if (ctrl_i.load) begin
      block_q[ctrl_i.word_idx] <= ctrl_i.load_word;
    end
  end

  // Result bus reads zero outside a valid output slot
  assign flags_o.out_word = ctrl_i.data_out_valid ? block_q[ctrl_i.word_idx] : '0;

endmodule

`default_nettype wire

/* sim.f */
hw/aes_hwpe_pkg.sv
hw/aes_ctrl_regs.sv
hw/aes_fsm.sv
hw/aes_streamer.sv
hw/aes_whitening_engine.sv
hw/aes_hwpe_top.sv
tb/tb_clock_gen.sv
tb/aes_hwpe_asserts.sv
tb/tb_aes_hwpe.sv

/* tb/aes_hwpe_asserts.sv */
// Protocol assertions on the FSM done pulse and the streamer memory port, bound into the top level
`default_nettype none

module aes_hwpe_asserts (
  input logic                    clk,
  input logic                    reset_n,
  input logic                    clear_i,
  input logic                    done_i,
  input aes_hwpe_pkg::mem_port_t mem_i,
  input logic                    src_done_i
);

  timeunit 1ns;
  timeprecision 100ps;

  logic rd_strobe;

  assign rd_strobe = mem_i.req && !mem_i.we;

  done_single_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    done_i |=> !done_i)
    else $error("done_o stayed high for more than one cycle");

  // Only one word transfer in flight
  no_req_during_read: assert property (@(posedge clk) disable iff (!reset_n || clear_i)
    rd_strobe |=> !mem_i.req)
    else $error("memory request issued while a read was outstanding");

  src_done_after_read: assert property (@(posedge clk) disable iff (!reset_n || clear_i)
    rd_strobe |=> src_done_i)
    else $error("src_done missing one cycle after a read strobe");

  src_done_needs_read: assert property (@(posedge clk) disable iff (!reset_n || clear_i)
    src_done_i |-> $past(rd_strobe))
    else $error("src_done without a read strobe in the previous cycle");

endmodule

bind aes_hwpe_top aes_hwpe_asserts aes_hwpe_asserts_i (
  .clk        (clk),
  .reset_n    (reset_n),
  .clear_i    (clear),
  .done_i     (done_o),
  .mem_i      (mem_o),
  .src_done_i (streamer_flags.src_done)
);

`default_nettype wire

/* tb/tb_aes_hwpe.sv */
// Testbench top running directed whitening jobs against a word memory model and a reference model
`default_nettype none

module tb_aes_hwpe;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 1024;
  // More than ten times the roughly 350 cycles that all jobs and register writes take
  localparam int TIMEOUT_CYCLES = 4000;

  logic                    clk;
  logic                    reset_n;
  logic                    cfg_we_i;
  aes_hwpe_pkg::reg_idx_t  cfg_idx_i;
  aes_hwpe_pkg::word_t     cfg_wdata_i;
  aes_hwpe_pkg::mem_port_t mem_bus;
  aes_hwpe_pkg::word_t     mem_rdata = '0;
  logic                    busy_o;
  logic                    done_o;

  aes_hwpe_pkg::word_t mem [MEM_WORDS];
  aes_hwpe_pkg::word_t ref_mem [MEM_WORDS];
  aes_hwpe_pkg::word_t lcg_state;
  int                  error_count = 0;
  int                  check_count = 0;
  int                  done_count = 0;
  int                  write_count = 0;
  int                  cycle_count = 0;

  tb_clock_gen tb_clock_gen_i (
    .clk_o (clk)
  );

  aes_hwpe_top #(
    .BLOCK_WORDS (4)
  ) aes_hwpe_top_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_idx_i   (cfg_idx_i),
    .cfg_wdata_i (cfg_wdata_i),
    .mem_o       (mem_bus),
    .mem_rdata_i (mem_rdata),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  // Word memory with read data one cycle after the strobe
  always @(posedge clk) begin
    if (mem_bus.req) begin
      if (mem_bus.addr[31:12] != '0 || mem_bus.addr[1:0] != 2'b00) begin
        error_count++;
        $display("Memory access at address %h lies outside the model", mem_bus.addr);
      end else if (mem_bus.we) begin
        mem[mem_bus.addr[11:2]] <= mem_bus.wdata;
        write_count++;
      end else begin
        mem_rdata <= mem[mem_bus.addr[11:2]];
      end
    end
    if (reset_n && done_o) begin
      done_count++;
    end
  end

  function automatic aes_hwpe_pkg::word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic aes_hwpe_pkg::block_t random_key();
    aes_hwpe_pkg::block_t key;
    for (int k = 0; k < 4; k++) begin
      key[32*k +: 32] = lcg_next();
    end
    return key;
  endfunction

  task automatic check_word(string name, aes_hwpe_pkg::word_t expected,
                            aes_hwpe_pkg::word_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic write_reg(aes_hwpe_pkg::reg_idx_t idx, aes_hwpe_pkg::word_t data);
    cfg_we_i    = 1'b1;
    cfg_idx_i   = idx;
    cfg_wdata_i = data;
    @(posedge clk);
    #1;
    cfg_we_i = 1'b0;
  endtask

  task automatic program_job(aes_hwpe_pkg::addr_t in_addr, aes_hwpe_pkg::addr_t out_addr,
                             aes_hwpe_pkg::word_t length, aes_hwpe_pkg::block_t key);
    write_reg(aes_hwpe_pkg::REG_INPUT_ADDR, in_addr);
    write_reg(aes_hwpe_pkg::REG_OUTPUT_ADDR, out_addr);
    write_reg(aes_hwpe_pkg::REG_BYTE_LENGTH, length);
    for (int k = 0; k < 4; k++) begin
      write_reg(aes_hwpe_pkg::reg_idx_t'(aes_hwpe_pkg::REG_KEY0 + k), key[32*k +: 32]);
    end
  endtask

  // Busy holds until the single done cycle and both drop after it
  task automatic wait_done(string name);
    @(negedge clk);
    while (!busy_o) begin
      @(negedge clk);
    end
    while (!done_o) begin
      check_flag({name, " busy before done"}, 1'b1, busy_o);
      @(negedge clk);
    end
    @(negedge clk);
    check_flag({name, " done after pulse"}, 1'b0, done_o);
    check_flag({name, " busy after done"}, 1'b0, busy_o);
    @(posedge clk);
    #1;
  endtask

  // Key word chosen by word index mod 4 over whole blocks
  task automatic apply_reference(aes_hwpe_pkg::addr_t in_addr, aes_hwpe_pkg::addr_t out_addr,
                                 aes_hwpe_pkg::word_t length, aes_hwpe_pkg::block_t key);
    int unsigned words;
    words = (length >> 4) * 4;
    for (int unsigned k = 0; k < words; k++) begin
      ref_mem[(out_addr >> 2) + k] = ref_mem[(in_addr >> 2) + k] ^ key[32*(k % 4) +: 32];
    end
  endtask

  task automatic compare_memory(string name);
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word($sformatf("%s mem[0x%03h]", name, i * 4), ref_mem[i], mem[i]);
    end
  endtask

  task automatic run_job(string name, aes_hwpe_pkg::addr_t in_addr,
                         aes_hwpe_pkg::addr_t out_addr, aes_hwpe_pkg::word_t length,
                         aes_hwpe_pkg::block_t key);
    int done_before;
    done_before = done_count;
    program_job(in_addr, out_addr, length, key);
    write_reg(aes_hwpe_pkg::REG_COMMAND, 32'h1);
    wait_done(name);
    check_word({name, " done pulses"}, 32'd1, aes_hwpe_pkg::word_t'(done_count - done_before));
    apply_reference(in_addr, out_addr, length, key);
    compare_memory(name);
  endtask

  task automatic test_one_block();
    run_job("one_block", 32'h000, 32'h400, 32'd16, random_key());
  endtask

  // Low length bits are ignored so three blocks remain
  task automatic test_three_blocks();
    run_job("three_blocks", 32'h104, 32'h50C, 32'h35, random_key());
  endtask

  task automatic test_zero_length();
    int writes_before;
    writes_before = write_count;
    run_job("zero_length", 32'h0C0, 32'h480, 32'd0, random_key());
    check_word("zero_length writes", 32'd0,
               aes_hwpe_pkg::word_t'(write_count - writes_before));
  endtask

  task automatic test_locked_params();
    aes_hwpe_pkg::block_t key;
    int                   done_before;
    key         = random_key();
    done_before = done_count;
    program_job(32'h240, 32'h640, 32'd32, key);
    write_reg(aes_hwpe_pkg::REG_COMMAND, 32'h1);
    // Rewrite everything while the job runs
    program_job(32'h000, 32'h700, 32'h100, random_key());
    wait_done("locked_params");
    check_word("locked_params done pulses", 32'd1,
               aes_hwpe_pkg::word_t'(done_count - done_before));
    apply_reference(32'h240, 32'h640, 32'd32, key);
    compare_memory("locked_params");
  endtask

  task automatic test_clear_abort();
    int done_before;
    int writes_before;
    done_before   = done_count;
    writes_before = write_count;
    program_job(32'h300, 32'h800, 32'd32, random_key());
    write_reg(aes_hwpe_pkg::REG_COMMAND, 32'h1);
    repeat (6) @(posedge clk);
    #1;
    write_reg(aes_hwpe_pkg::REG_COMMAND, 32'h2);
    repeat (2) @(negedge clk);
    check_flag("clear_abort busy after clear", 1'b0, busy_o);
    repeat (40) @(posedge clk);
    #1;
    check_word("clear_abort done pulses", 32'd0,
               aes_hwpe_pkg::word_t'(done_count - done_before));
    check_word("clear_abort writes", 32'd0,
               aes_hwpe_pkg::word_t'(write_count - writes_before));
    compare_memory("clear_abort");
    run_job("after_clear", 32'h300, 32'h800, 32'd32, random_key());
  endtask

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the DUT did not finish its jobs within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    reset_n     = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_idx_i   = '0;
    cfg_wdata_i = '0;
    lcg_state   = 32'd96828;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = lcg_next() ^ aes_hwpe_pkg::word_t'(i * 4);
      ref_mem[i] = mem[i];
    end
    repeat (4) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(negedge clk);
    check_flag("reset busy", 1'b0, busy_o);
    check_flag("reset done", 1'b0, done_o);
    check_flag("reset mem req", 1'b0, mem_bus.req);
    @(posedge clk);
    #1;
    test_one_block();
    test_three_blocks();
    test_zero_length();
    test_locked_params();
    test_clear_abort();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Free-running testbench clock source with an 8 ns period, instantiated by the testbench top
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;

endmodule

`default_nettype wire
